//--- source/fb_pkg.sv
`default_nettype none

package fb_pkg;

	// Wave and word geometry
	localparam int LANES = 4;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int FB_WORDS = 2048;
	localparam int FB_ADDR_W = $clog2(FB_WORDS);

	// Grant to ready distance through the arbiter
	localparam int PIPE_DEPTH = 3;

	// Byte window mapped onto the frame buffer
	localparam logic [31:0] FB_BASE = 32'h3000;
	localparam logic [31:0] FB_LIMIT = 32'h5000;

	typedef logic [DATA_W-1:0] word_t;
	// All zero strobe means a read
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [31:0] sys_addr_t;
	typedef logic [FB_ADDR_W-1:0] fb_addr_t;
	typedef logic [LANES-1:0] lane_mask_t;
	typedef logic [$clog2(LANES)-1:0] lane_id_t;

endpackage

`default_nettype wire

//--- source/fb_sram.sv
`default_nettype none

module fb_sram import fb_pkg::*; (
	input wire clk,
	input wire rd_en,
	input wire wr_en,
	input wire strb_t byte_en,
	input wire fb_addr_t addr,
	input wire word_t wdata,
	output word_t rdata
);

	word_t mem [FB_WORDS];

	// Byte lanes written independently
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (byte_en[b]) begin
					mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// Registered read, holds until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- source/fb_arbiter.sv
`default_nettype none

module fb_arbiter import fb_pkg::*; (
	input wire clk,
	input wire nRST,
	input wire fw_mode_n,
	// Lane side
	input wire lane_mask_t request,
	input wire fb_addr_t req_addr [LANES],
	input wire strb_t req_wstrb [LANES],
	input wire word_t req_wdata [LANES],
	// Firmware side
	input wire fw_rd_en,
	input wire fw_wr_en,
	input wire fb_addr_t fw_addr,
	input wire strb_t fw_byte_en,
	input wire word_t fw_wdata,
	output lane_mask_t grant,
	output lane_mask_t ready,
	output word_t rdata,
	output word_t fw_rdata
);

	lane_mask_t req_eff;
	lane_id_t sel;

	// Stage A drives the SRAM
	logic a_valid;
	lane_id_t a_id;
	fb_addr_t a_addr;
	strb_t a_wstrb;
	word_t a_wdata;

	// Stage B waits on the SRAM read
	logic b_valid;
	lane_id_t b_id;
	logic b_read;

	// Stage C returns to the lane
	logic c_valid;
	lane_id_t c_id;
	word_t c_rdata;

	logic sram_rd_en;
	logic sram_wr_en;
	strb_t sram_byte_en;
	fb_addr_t sram_addr;
	word_t sram_wdata;
	word_t sram_rdata;

	fb_sram u_sram (
		.clk(clk),
		.rd_en(sram_rd_en),
		.wr_en(sram_wr_en),
		.byte_en(sram_byte_en),
		.addr(sram_addr),
		.wdata(sram_wdata),
		.rdata(sram_rdata)
	);

	// Lowest lane wins, nothing is granted in firmware mode
	always_comb begin
		req_eff = request & {LANES{fw_mode_n}};
		sel = '0;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (req_eff[i]) begin
				sel = lane_id_t'(i);
			end
		end
		grant = (|req_eff) ? (lane_mask_t'(1) << sel) : '0;
	end

	// Firmware bypasses the pipeline entirely
	always_comb begin
		if (!fw_mode_n) begin
			sram_rd_en = fw_rd_en;
			sram_wr_en = fw_wr_en;
			sram_byte_en = fw_byte_en;
			sram_addr = fw_addr;
			sram_wdata = fw_wdata;
		end else begin
			sram_rd_en = a_valid && (a_wstrb == '0);
			sram_wr_en = a_valid && (a_wstrb != '0);
			sram_byte_en = a_wstrb;
			sram_addr = a_addr;
			sram_wdata = a_wdata;
		end
	end

	assign fw_rdata = fw_mode_n ? '0 : sram_rdata;

	always_ff @(posedge clk) begin
		if (!nRST) begin
			a_valid <= 1'b0;
			b_valid <= 1'b0;
			c_valid <= 1'b0;
		end else begin
			a_valid <= |req_eff;
			b_valid <= a_valid;
			c_valid <= b_valid;
		end
	end

	// Payload follows the valid bits down the pipe
	always_ff @(posedge clk) begin
		if (|req_eff) begin
			a_id <= sel;
			a_addr <= req_addr[sel];
			a_wstrb <= req_wstrb[sel];
			a_wdata <= req_wdata[sel];
		end
		b_id <= a_id;
		b_read <= (a_wstrb == '0);
		c_id <= b_id;
		if (b_valid) begin
			c_rdata <= b_read ? sram_rdata : '0;
		end
	end

	assign ready = c_valid ? (lane_mask_t'(1) << c_id) : '0;
	assign rdata = c_rdata;

endmodule

`default_nettype wire

//--- source/lane_tracker.sv
`default_nettype none

module lane_tracker import fb_pkg::*; (
	input wire clk,
	input wire nRST,
	input wire fw_mode_n,
	// Outside lane
	input wire lane_valid,
	input wire sys_addr_t lane_addr,
	input wire strb_t lane_wstrb,
	input wire word_t lane_wdata,
	// Wave control and arbiter return
	input wire pending,
	input wire wave_release,
	input wire grant,
	input wire ready,
	input wire word_t rdata,
	output logic request,
	output fb_addr_t req_addr,
	output strb_t req_wstrb,
	output word_t req_wdata,
	output logic done,
	output logic out_of_window,
	output word_t lane_rdata
);

	logic in_window;
	sys_addr_t offset;
	logic member;
	logic granted;
	logic served;
	word_t data_q;

	assign in_window = (lane_addr >= FB_BASE) && (lane_addr < FB_LIMIT);
	assign offset = lane_addr - FB_BASE;

	// Byte offset to word index
	assign req_addr = offset[FB_ADDR_W+1:2];
	assign req_wstrb = lane_wstrb;
	assign req_wdata = lane_wdata;
	assign out_of_window = lane_valid && !in_window;

	// Membership frozen when the wave starts
	always_ff @(posedge clk) begin
		if (!nRST) begin
			member <= 1'b0;
		end else if (!pending) begin
			member <= lane_valid && fw_mode_n;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRST) begin
			granted <= 1'b0;
			served <= 1'b0;
		end else if (wave_release) begin
			granted <= 1'b0;
			served <= 1'b0;
		end else begin
			if (grant) begin
				granted <= 1'b1;
			end
			if (ready) begin
				served <= 1'b1;
			end
		end
	end

	assign request = fw_mode_n && pending && member && in_window && !granted;

	// Out of window lanes finish without touching memory
	assign done = served || (pending && member && !in_window);

	// Writes return zero
	always_ff @(posedge clk) begin
		if (ready) begin
			data_q <= (lane_wstrb != '0) ? '0 : rdata;
		end
	end

	assign lane_rdata = in_window ? data_q : '0;

endmodule

`default_nettype wire

//--- source/wave_sync.sv
`default_nettype none

module wave_sync import fb_pkg::*; (
	input wire clk,
	input wire nRST,
	input wire fw_mode_n,
	input wire lane_mask_t lane_valid,
	input wire lane_mask_t done,
	input wire lane_mask_t out_of_window,
	output logic pending,
	output logic wave_release,
	output lane_mask_t lane_ready,
	output logic addr_fault
);

	typedef enum logic {
		IDLE,
		PEND
	} state_t;

	state_t state;
	lane_mask_t active;
	logic all_done;

	assign pending = (state == PEND);
	assign all_done = ((done & active) == active);

	always_ff @(posedge clk) begin
		if (!nRST) begin
			state <= IDLE;
			active <= '0;
			wave_release <= 1'b0;
			lane_ready <= '0;
			addr_fault <= 1'b0;
		end else begin
			wave_release <= 1'b0;
			lane_ready <= '0;
			addr_fault <= 1'b0;
			case (state)
				IDLE: begin
					// No new wave in the release cycle, trackers are still clearing
					if (fw_mode_n && !wave_release && (|lane_valid)) begin
						active <= lane_valid;
						state <= PEND;
					end
				end
				PEND: begin
					if (all_done) begin
						wave_release <= 1'b1;
						lane_ready <= active;
						addr_fault <= |(out_of_window & active);
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/fb_subsystem.sv
`default_nettype none

module fb_subsystem import fb_pkg::*; (
	input wire clk,
	input wire nRST,
	// Lanes
	input wire lane_mask_t lane_valid,
	input wire sys_addr_t lane_addr [LANES],
	input wire strb_t lane_wstrb [LANES],
	input wire word_t lane_wdata [LANES],
	output wire lane_mask_t lane_ready,
	output wire word_t lane_rdata [LANES],
	output wire addr_fault,
	// Firmware port
	input wire fw_mode_n,
	input wire fw_rd_en,
	input wire fw_wr_en,
	input wire fb_addr_t fw_addr,
	input wire strb_t fw_byte_en,
	input wire word_t fw_wdata,
	output wire word_t fw_rdata
);

	wire lane_mask_t request;
	wire fb_addr_t req_addr [LANES];
	wire strb_t req_wstrb [LANES];
	wire word_t req_wdata [LANES];
	wire lane_mask_t grant;
	wire lane_mask_t ready;
	wire word_t arb_rdata;
	wire lane_mask_t done;
	wire lane_mask_t out_of_window;
	wire pending;
	wire wave_release;

	fb_arbiter u_arbiter (
		.clk(clk),
		.nRST(nRST),
		.fw_mode_n(fw_mode_n),
		.request(request),
		.req_addr(req_addr),
		.req_wstrb(req_wstrb),
		.req_wdata(req_wdata),
		.fw_rd_en(fw_rd_en),
		.fw_wr_en(fw_wr_en),
		.fw_addr(fw_addr),
		.fw_byte_en(fw_byte_en),
		.fw_wdata(fw_wdata),
		.grant(grant),
		.ready(ready),
		.rdata(arb_rdata),
		.fw_rdata(fw_rdata)
	);

	// One tracker per lane, all sharing the arbiter read data
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		lane_tracker u_tracker (
			.clk(clk),
			.nRST(nRST),
			.fw_mode_n(fw_mode_n),
			.lane_valid(lane_valid[i]),
			.lane_addr(lane_addr[i]),
			.lane_wstrb(lane_wstrb[i]),
			.lane_wdata(lane_wdata[i]),
			.pending(pending),
			.wave_release(wave_release),
			.grant(grant[i]),
			.ready(ready[i]),
			.rdata(arb_rdata),
			.request(request[i]),
			.req_addr(req_addr[i]),
			.req_wstrb(req_wstrb[i]),
			.req_wdata(req_wdata[i]),
			.done(done[i]),
			.out_of_window(out_of_window[i]),
			.lane_rdata(lane_rdata[i])
		);
	end

	wave_sync u_sync (
		.clk(clk),
		.nRST(nRST),
		.fw_mode_n(fw_mode_n),
		.lane_valid(lane_valid),
		.done(done),
		.out_of_window(out_of_window),
		.pending(pending),
		.wave_release(wave_release),
		.lane_ready(lane_ready),
		.addr_fault(addr_fault)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic nRST
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held for 8 rising edges, released on a falling edge
	initial begin
		nRST = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nRST = 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/fb_asserts.sv
`default_nettype none

module fb_asserts import fb_pkg::*; (
	input wire clk,
	input wire nRST,
	input wire fw_mode_n,
	input wire lane_mask_t request,
	input wire lane_mask_t grant,
	input wire lane_mask_t ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// Lowest requesting lane only, none in firmware mode
	grant_lowest: assert property (@(posedge clk) disable iff (!nRST)
		grant == (fw_mode_n ? (request & (~request + lane_mask_t'(1))) : '0))
		else $error("grant is not the lowest requesting lane");

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		// Every ready pulse traces back to a grant through the pipe
		ready_after_grant: assert property (@(posedge clk) disable iff (!nRST)
			ready[i] |-> $past(grant[i], PIPE_DEPTH))
			else $error("ready without a grant PIPE_DEPTH cycles earlier");

		// No granted access is lost in the pipe
		grant_returns: assert property (@(posedge clk) disable iff (!nRST)
			$past(grant[i], PIPE_DEPTH) |-> ready[i])
			else $error("grant without a ready PIPE_DEPTH cycles later");
	end

endmodule

bind fb_arbiter fb_asserts u_asserts (
	.clk(clk),
	.nRST(nRST),
	.fw_mode_n(fw_mode_n),
	.request(request),
	.grant(grant),
	.ready(ready)
);

`default_nettype wire

//--- dv/fb_tb.sv
`default_nettype none

module fb_tb import fb_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_RAND = 50;
	localparam int TOTAL_WAVES = NUM_RAND + 6;
	localparam int TIMEOUT_NS = TOTAL_WAVES * 40 * 10 + 2000;

	logic clk;
	logic nRST;
	lane_mask_t lane_valid;
	lane_mask_t lane_ready;
	sys_addr_t lane_addr [LANES];
	strb_t lane_wstrb [LANES];
	word_t lane_wdata [LANES];
	word_t lane_rdata [LANES];
	logic addr_fault;
	logic fw_mode_n;
	logic fw_rd_en;
	logic fw_wr_en;
	fb_addr_t fw_addr;
	strb_t fw_byte_en;
	word_t fw_wdata;
	word_t fw_rdata;

	word_t model [int];
	word_t exp_rdata [LANES];
	logic exp_fault;
	int errors = 0;
	logic [31:0] lfsr = 32'd81;

	tb_clock u_clock (.clk(clk), .nRST(nRST));

	fb_subsystem uut (
		.clk(clk), .nRST(nRST),
		.lane_valid(lane_valid), .lane_addr(lane_addr),
		.lane_wstrb(lane_wstrb), .lane_wdata(lane_wdata),
		.lane_ready(lane_ready), .lane_rdata(lane_rdata), .addr_fault(addr_fault),
		.fw_mode_n(fw_mode_n), .fw_rd_en(fw_rd_en), .fw_wr_en(fw_wr_en),
		.fw_addr(fw_addr), .fw_byte_en(fw_byte_en), .fw_wdata(fw_wdata),
		.fw_rdata(fw_rdata)
	);

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic word_t merge(input word_t old, input word_t wd, input strb_t s);
		word_t res;
		res = old;
		for (int b = 0; b < STRB_W; b++) begin
			if (s[b]) begin
				res[b*8 +: 8] = wd[b*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error @%0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_mask(input string what, input lane_mask_t got, input lane_mask_t exp);
		if (got !== exp) begin
			$display("error @%0t: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic fw_write(input int idx, input word_t d, input strb_t s);
		@(negedge clk);
		fw_wr_en = 1'b1;
		fw_addr = idx[FB_ADDR_W-1:0];
		fw_byte_en = s;
		fw_wdata = d;
		model[idx] = merge(model.exists(idx) ? model[idx] : '0, d, s);
		@(negedge clk);
		fw_wr_en = 1'b0;
	endtask

	task automatic fw_read(input int idx);
		@(negedge clk);
		fw_rd_en = 1'b1;
		fw_addr = idx[FB_ADDR_W-1:0];
		@(negedge clk);
		fw_rd_en = 1'b0;
		check_word("fw_rdata", fw_rdata, model[idx]);
	endtask

	// Lanes applied lowest index first, as the arbiter serves them
	task automatic start_wave(input lane_mask_t mask);
		int idx;
		@(negedge clk);
		exp_fault = 1'b0;
		for (int i = 0; i < LANES; i++) begin
			exp_rdata[i] = '0;
			if (mask[i]) begin
				if (lane_addr[i] < FB_BASE || lane_addr[i] >= FB_LIMIT) begin
					exp_fault = 1'b1;
				end else begin
					idx = int'((lane_addr[i] - FB_BASE) >> 2);
					if (lane_wstrb[i] == '0) begin
						exp_rdata[i] = model[idx];
					end else begin
						model[idx] = merge(model[idx], lane_wdata[i], lane_wstrb[i]);
					end
				end
			end
		end
		lane_valid = mask;
	endtask

	task automatic finish_wave(input lane_mask_t mask);
		int n;
		n = 0;
		while (lane_ready == '0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (n >= 100) begin
			$display("lane_ready never came for the wave with lanes %b", mask);
			errors++;
		end else begin
			check_mask("lane_ready", lane_ready, mask);
			check_mask("addr_fault", lane_mask_t'(addr_fault), lane_mask_t'(exp_fault));
			for (int i = 0; i < LANES; i++) begin
				if (mask[i]) begin
					check_word($sformatf("lane_rdata[%0d]", i),
						lane_rdata[i], exp_rdata[i]);
				end
			end
		end
		lane_valid = '0;
		@(negedge clk);
		check_mask("lane_ready after pulse", lane_ready, '0);
		check_mask("addr_fault after pulse", lane_mask_t'(addr_fault), '0);
	endtask

	// Word index drawn from the two preloaded regions
	task automatic random_lane(input int i);
		logic [31:0] r;
		int idx;
		r = rand_bits(6);
		idx = r[5] ? 2016 + int'(r[4:0]) : int'(r[4:0]);
		lane_addr[i] = FB_BASE + (sys_addr_t'(idx) << 2);
		r = rand_bits(5);
		lane_wstrb[i] = r[4] ? r[3:0] : 4'h0;
		lane_wdata[i] = rand_bits(32);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		lane_mask_t mask;
		lane_valid = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_addr[i] = FB_BASE;
			lane_wstrb[i] = '0;
			lane_wdata[i] = '0;
		end
		fw_mode_n = 1'b0;
		fw_rd_en = 1'b0;
		fw_wr_en = 1'b0;
		fw_addr = '0;
		fw_byte_en = '0;
		fw_wdata = '0;
		@(posedge nRST);
		@(negedge clk);

		// Reset state and firmware round trip
		check_mask("lane_ready after reset", lane_ready, '0);
		check_mask("addr_fault after reset", lane_mask_t'(addr_fault), '0);
		fw_write(40, 32'hA5A5_0F0F, 4'hF);
		fw_read(40);

		// Preload both regions, then one all-lane read wave
		for (int k = 0; k < 32; k++) begin
			fw_write(k, rand_bits(32), 4'hF);
			fw_write(2016 + k, rand_bits(32), 4'hF);
		end
		@(negedge clk);
		fw_mode_n = 1'b1;
		for (int i = 0; i < LANES; i++) begin
			random_lane(i);
			lane_wstrb[i] = '0;
		end
		start_wave(4'hF);
		finish_wave(4'hF);

		for (int w = 0; w < NUM_RAND; w++) begin
			r = rand_bits(4);
			mask = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
			for (int i = 0; i < LANES; i++) begin
				random_lane(i);
			end
			start_wave(mask);
			finish_wave(mask);
		end

		// Several lanes on one word, overlapping strobes
		for (int i = 0; i < LANES; i++) begin
			lane_addr[i] = FB_BASE + 32'h1C;
			lane_wdata[i] = rand_bits(32);
		end
		lane_wstrb[0] = 4'b0011;
		lane_wstrb[1] = 4'b0110;
		lane_wstrb[2] = 4'b1100;
		lane_wstrb[3] = 4'b1001;
		start_wave(4'hF);
		finish_wave(4'hF);
		lane_wstrb[0] = 4'h0;
		start_wave(4'h1);
		finish_wave(4'h1);

		// Out of window lanes above and below the window
		lane_addr[0] = FB_BASE + 32'hC;
		lane_wstrb[0] = 4'hF;
		lane_wdata[0] = rand_bits(32);
		lane_addr[1] = FB_LIMIT + 32'h4;
		lane_wstrb[1] = 4'hF;
		lane_addr[2] = FB_BASE - 32'h4;
		lane_wstrb[2] = 4'h0;
		start_wave(4'h7);
		finish_wave(4'h7);
		lane_wstrb[0] = 4'h0;
		start_wave(4'h1);
		finish_wave(4'h1);

		// Lane raised during firmware mode waits for the mode to end
		fw_mode_n = 1'b0;
		lane_addr[0] = FB_BASE + 32'h28;
		lane_wstrb[0] = 4'h0;
		start_wave(4'h1);
		repeat (10) begin
			@(negedge clk);
			check_mask("lane_ready in firmware mode", lane_ready, '0);
		end
		fw_mode_n = 1'b1;
		finish_wave(4'h1);

		// Firmware read back of every preloaded word
		fw_mode_n = 1'b0;
		for (int k = 0; k < 32; k++) begin
			fw_read(k);
			fw_read(2016 + k);
		end
		fw_read(40);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/fb_pkg.sv
source/fb_sram.sv
source/fb_arbiter.sv
source/lane_tracker.sv
source/wave_sync.sv
source/fb_subsystem.sv
dv/tb_clock.sv
dv/fb_asserts.sv
dv/fb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the frame-buffer testbench with Verilator

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f vlog.f --top-module fb_tb -o fb_sim \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/fb_sim > sim.log 2>&1 || echo "Simulator returned a nonzero status"

grep -q "Simulation finished: PASS" sim.log && exit 0 || { cat sim.log; exit 1; }
